// File: Bender.yml
package:
  name: scene_playback

sources:
  - rtl/scene_pkg.sv
  - rtl/scene_loader.sv
  - rtl/memory_request_arbiter.sv
  - rtl/scene_retriever.sv
  - rtl/fifo.sv
  - rtl/frame_buffer_handler.sv
  - rtl/scene_top.sv
  - target: test
    files:
      - tb/tb_scene_top.sv

// File: rtl/fifo.sv
`timescale 1ns/1ps

module fifo
    import scene_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         push,
    input  pixel_entry_t push_data,
    output logic         full,
    input  logic         pop,
    output pixel_entry_t head,
    output logic         empty
);

    pixel_entry_t                 entries [2**FIFO_DEPTH_LOG2];
    logic [FIFO_DEPTH_LOG2-1:0]   wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0]   rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]     count;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Count tops out at the depth, so its MSB alone means full
    assign full  = count[FIFO_DEPTH_LOG2];
    assign empty = (count == '0);
    assign head  = entries[rd_ptr];

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule : fifo

// File: rtl/frame_buffer_handler.sv
`timescale 1ns/1ps

module frame_buffer_handler
    import scene_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  pixel_entry_t head,
    input  logic         empty,
    output logic         pop,
    output logic         pix_valid,
    input  logic         pix_ready,
    output rgb_t         pix_rgb,
    output pix_x_t       pix_x,
    output pix_y_t       pix_y,
    output logic         frame_done
);

    run_t rep_cnt;
    logic xfer;
    logic last_col;
    logic last_row;

    assign pix_valid  = !empty;
    assign pix_rgb    = head.rgb;
    assign xfer       = pix_valid && pix_ready;
    assign pop        = xfer && (rep_cnt == head.run);
    assign last_col   = (pix_x == pix_x_t'(FRAME_W - 1));
    assign last_row   = (pix_y == pix_y_t'(FRAME_H - 1));
    assign frame_done = xfer && last_col && last_row;

    always_ff @(posedge clk) begin
        if (rst) begin
            rep_cnt <= '0;
            pix_x   <= '0;
            pix_y   <= '0;
        end else if (xfer) begin
            rep_cnt <= pop ? '0 : run_t'(rep_cnt + 1'b1);
            if (last_col) begin
                pix_x <= '0;
                pix_y <= last_row ? '0 : pix_y_t'(pix_y + 1'b1);
            end else begin
                pix_x <= pix_x_t'(pix_x + 1'b1);
            end
        end
    end

    // Head only moves on a pop, so a stalled pixel must not change
    a_stall_holds: assert property (@(posedge clk) disable iff (rst)
        (pix_valid && !pix_ready) |=>
            (pix_valid && $stable(pix_rgb) && $stable(pix_x) && $stable(pix_y)));

endmodule : frame_buffer_handler

// File: rtl/memory_request_arbiter.sv
`timescale 1ns/1ps

module memory_request_arbiter
    import scene_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_req,
    input  mem_addr_t wr_addr,
    input  word_t     wr_data,
    output logic      wr_ack,
    input  logic      rd_req,
    input  mem_addr_t rd_addr,
    output logic      rd_ack,
    output word_t     rd_data
);

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_WR,
        GNT_RD
    } grant_t;

    grant_t grant;
    word_t  mem [MEM_WORDS];
    logic   wr_start;
    logic   rd_start;

    // Writer wins a same-cycle tie
    assign wr_start = (grant == GNT_NONE) && wr_req;
    assign rd_start = (grant == GNT_NONE) && !wr_req && rd_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant  <= GNT_NONE;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            case (grant)
                GNT_NONE: begin
                    if (wr_start) begin
                        grant  <= GNT_WR;
                        wr_ack <= 1'b1;
                    end else if (rd_start) begin
                        grant  <= GNT_RD;
                        rd_ack <= 1'b1;
                    end
                end
                GNT_WR: begin
                    if (!wr_req) begin
                        wr_ack <= 1'b0;
                        grant  <= GNT_NONE;
                    end
                end
                GNT_RD: begin
                    if (!rd_req) begin
                        rd_ack <= 1'b0;
                        grant  <= GNT_NONE;
                    end
                end
                default: begin
                    grant <= GNT_NONE;
                end
            endcase
        end
    end

    // Write lands as the ack rises, read data held for the whole ack
    always_ff @(posedge clk) begin
        if (wr_start) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_start) begin
            rd_data <= mem[rd_addr];
        end
    end

    a_acks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(wr_ack && rd_ack));

endmodule : memory_request_arbiter

// File: rtl/scene_loader.sv
`timescale 1ns/1ps

module scene_loader
    import scene_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       load_end,
    output logic       wr_req,
    output mem_addr_t  wr_addr,
    output word_t      wr_data,
    input  logic       wr_ack,
    output logic       scene_loaded,
    output mem_addr_t  scene_words
);

    logic [1:0] byte_cnt;
    word_t      word_q;
    logic       flush_pending;

    // Lanes fill from the bottom, so a short word is zero-padded on top
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (byte_cnt == 2'd0) begin
                word_q <= {24'h000000, byte_data};
            end else begin
                word_q[{byte_cnt, 3'b000} +: 8] <= byte_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt      <= 2'd0;
            wr_req        <= 1'b0;
            wr_addr       <= '0;
            flush_pending <= 1'b0;
            scene_loaded  <= 1'b0;
        end else begin
            if (byte_valid) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin
                    wr_req <= 1'b1;
                end
            end
            if (wr_req && wr_ack) begin
                wr_req  <= 1'b0;
                wr_addr <= mem_addr_t'(wr_addr + 1'b1);
            end
            if (load_end) begin
                if (byte_cnt != 2'd0) begin
                    wr_req        <= 1'b1;
                    flush_pending <= 1'b1;
                    byte_cnt      <= 2'd0;
                end else begin
                    scene_loaded <= 1'b1;
                end
            end
            // Final flush done once its ack has dropped
            if (flush_pending && !wr_req && !wr_ack) begin
                flush_pending <= 1'b0;
                scene_loaded  <= 1'b1;
            end
        end
    end

    assign wr_data     = word_q;
    assign scene_words = wr_addr;

    a_no_byte_during_write: assert property (@(posedge clk) disable iff (rst)
        (byte_valid || load_end) |-> (!wr_req && !wr_ack));

endmodule : scene_loader

// File: rtl/scene_pkg.sv
package scene_pkg;

    // Memory sizing
    localparam int MEM_WORDS = 256;

    // Pixel buffer holds 2**FIFO_DEPTH_LOG2 entries
    localparam int FIFO_DEPTH_LOG2 = 3;

    // Output frame geometry
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 4;

    // Fewest cycles between two scene byte strobes
    localparam int MIN_BYTE_GAP = 8;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  mem_addr_t;
    typedef logic [23:0] rgb_t;

    // Entry yields run + 1 pixels
    typedef logic [7:0]  run_t;

    typedef logic [3:0]  pix_x_t;
    typedef logic [1:0]  pix_y_t;

    // Same bit layout as a memory word
    typedef struct packed {
        run_t run;
        rgb_t rgb;
    } pixel_entry_t;

endpackage : scene_pkg

// File: rtl/scene_retriever.sv
`timescale 1ns/1ps

module scene_retriever
    import scene_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         scene_loaded,
    input  mem_addr_t    scene_words,
    output logic         rd_req,
    output mem_addr_t    rd_addr,
    input  logic         rd_ack,
    input  word_t        rd_data,
    output logic         push,
    output pixel_entry_t push_data,
    input  logic         full
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_PUSH,
        ST_DONE
    } state_t;

    state_t    state;
    mem_addr_t next_addr;

    assign next_addr = mem_addr_t'(rd_addr + 1'b1);

    always_ff @(posedge clk) begin
        if (state == ST_REQ && rd_ack) begin
            push_data <= pixel_entry_t'(rd_data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            rd_req  <= 1'b0;
            rd_addr <= '0;
            push    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (scene_loaded) begin
                        if (scene_words == '0) begin
                            state <= ST_DONE;
                        end else begin
                            rd_req <= 1'b1;
                            state  <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    if (rd_ack) begin
                        rd_req <= 1'b0;
                        state  <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Only producer, so a free slot seen now is still free next cycle
                    if (!rd_ack && !full) begin
                        push  <= 1'b1;
                        state <= ST_PUSH;
                    end
                end
                ST_PUSH: begin
                    push    <= 1'b0;
                    rd_addr <= next_addr;
                    if (next_addr == scene_words) begin
                        state <= ST_DONE;
                    end else begin
                        rd_req <= 1'b1;
                        state  <= ST_REQ;
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

endmodule : scene_retriever

// File: rtl/scene_top.sv
`timescale 1ns/1ps

module scene_top
    import scene_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       load_end,
    output logic       scene_loaded,
    output logic       pix_valid,
    input  logic       pix_ready,
    output rgb_t       pix_rgb,
    output pix_x_t     pix_x,
    output pix_y_t     pix_y,
    output logic       frame_done
);

    logic         wr_req, wr_ack;
    mem_addr_t    wr_addr;
    word_t        wr_data;
    logic         rd_req, rd_ack;
    mem_addr_t    rd_addr;
    word_t        rd_data;
    mem_addr_t    scene_words;
    logic         pb_push, pb_pop, pb_full, pb_empty;
    pixel_entry_t pb_push_data, pb_head;

    scene_loader sl (
        .clk, .rst, .byte_valid, .byte_data, .load_end,
        .wr_req, .wr_addr, .wr_data, .wr_ack,
        .scene_loaded, .scene_words
    );

    memory_request_arbiter mra (
        .clk, .rst,
        .wr_req, .wr_addr, .wr_data, .wr_ack,
        .rd_req, .rd_addr, .rd_ack, .rd_data
    );

    scene_retriever sr (
        .clk, .rst, .scene_loaded, .scene_words,
        .rd_req, .rd_addr, .rd_ack, .rd_data,
        .push(pb_push), .push_data(pb_push_data), .full(pb_full)
    );

    // Pixel buffer between retriever and handler
    fifo pb (
        .clk, .rst,
        .push(pb_push), .push_data(pb_push_data), .full(pb_full),
        .pop(pb_pop), .head(pb_head), .empty(pb_empty)
    );

    frame_buffer_handler fbh (
        .clk, .rst, .head(pb_head), .empty(pb_empty), .pop(pb_pop),
        .pix_valid, .pix_ready, .pix_rgb, .pix_x, .pix_y, .frame_done
    );

endmodule : scene_top

// File: tb.f
rtl/scene_pkg.sv
rtl/scene_loader.sv
rtl/memory_request_arbiter.sv
rtl/scene_retriever.sv
rtl/fifo.sv
rtl/frame_buffer_handler.sv
rtl/scene_top.sv
tb/tb_scene_top.sv

// File: tb/tb_scene_top.sv
`timescale 1ns/1ps

module tb_scene_top
    import scene_pkg::*;
();

    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

    // Upper bounds over all scenes, the back-pressure scene has runs of at most 7
    localparam int TOTAL_BYTES     = 12 + 6 + 24 + 40;
    localparam int TOTAL_PIXELS    = 9 + 5 + 48 + 155;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * MIN_BYTE_GAP * 4 + TOTAL_PIXELS * 8 + 1000;
    localparam int LOAD_WAIT_LIMIT = 50;

    logic       clk;
    logic       rst;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       load_end;
    logic       scene_loaded;
    logic       pix_valid;
    logic       pix_ready;
    rgb_t       pix_rgb;
    pix_x_t     pix_x;
    pix_y_t     pix_y;
    logic       frame_done;

    integer     seed;
    logic [7:0] byte_q[$];
    rgb_t       exp_rgb_q[$];

    scene_top dut (
        .clk, .rst, .byte_valid, .byte_data, .load_end, .scene_loaded,
        .pix_valid, .pix_ready, .pix_rgb, .pix_x, .pix_y, .frame_done
    );

    always #50 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    task automatic stop_failed();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (exp !== act) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_x(input string name, input pix_x_t exp, input pix_x_t act);
        if (exp !== act) begin
            $display("FAIL time %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_y(input string name, input pix_y_t exp, input pix_y_t act);
        if (exp !== act) begin
            $display("FAIL time %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL time %0t %s expected %b actual %b", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst        <= 1'b1;
        byte_valid <= 1'b0;
        load_end   <= 1'b0;
        pix_ready  <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Words are little-endian byte groups, a short tail is zero on top
    task automatic build_model();
        word_t w;
        int    n;
        int    run;
        exp_rgb_q.delete();
        n = byte_q.size();
        for (int i = 0; i < n; i += 4) begin
            w = '0;
            for (int k = 0; k < 4 && i + k < n; k++) begin
                w[8*k +: 8] = byte_q[i+k];
            end
            run = int'(w[31:24]);
            for (int p = 0; p <= run; p++) begin
                exp_rgb_q.push_back(w[23:0]);
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= b;
        @(negedge clk);
        check_bit("scene_loaded", 1'b0, scene_loaded);
        check_bit("pix_valid", 1'b0, pix_valid);
        @(posedge clk);
        byte_valid <= 1'b0;
        repeat (MIN_BYTE_GAP - 1) @(posedge clk);
    endtask

    task automatic send_load_end();
        @(posedge clk);
        load_end <= 1'b1;
        @(posedge clk);
        load_end <= 1'b0;
    endtask

    task automatic wait_scene_loaded();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!scene_loaded) begin
            if (waited == LOAD_WAIT_LIMIT) begin
                abort_run("scene_loaded did not rise after load_end");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // Sampled on the falling edge, a transfer completes on the next rising edge
    task automatic collect_pixels(input bit random_ready);
        int          idx;
        bit          stalled;
        logic        xfer;
        logic        exp_done;
        logic [31:0] r;
        rgb_t        held_rgb;
        pix_x_t      held_x;
        pix_y_t      held_y;
        idx     = 0;
        stalled = 1'b0;
        while (idx < exp_rgb_q.size()) begin
            @(posedge clk);
            if (random_ready) begin
                r = $random(seed);
                pix_ready <= r[0];
            end else begin
                pix_ready <= 1'b1;
            end
            @(negedge clk);
            if (stalled) begin
                check_bit("pix_valid", 1'b1, pix_valid);
                check_rgb("pix_rgb", held_rgb, pix_rgb);
                check_x("pix_x", held_x, pix_x);
                check_y("pix_y", held_y, pix_y);
            end
            xfer     = pix_valid && pix_ready;
            exp_done = xfer && (idx % FRAME_PIXELS == FRAME_PIXELS - 1);
            check_bit("frame_done", exp_done, frame_done);
            if (xfer) begin
                check_rgb("pix_rgb", exp_rgb_q[idx], pix_rgb);
                check_x("pix_x", pix_x_t'(idx % FRAME_W), pix_x);
                check_y("pix_y", pix_y_t'((idx / FRAME_W) % FRAME_H), pix_y);
                idx++;
            end
            stalled  = pix_valid && !pix_ready;
            held_rgb = pix_rgb;
            held_x   = pix_x;
            held_y   = pix_y;
        end
        @(posedge clk);
        pix_ready <= 1'b1;
    endtask

    // Nothing may follow the last modelled pixel
    task automatic check_stream_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("pix_valid", 1'b0, pix_valid);
            check_bit("frame_done", 1'b0, frame_done);
        end
    endtask

    task automatic run_scene(input bit random_ready);
        apply_reset();
        build_model();
        foreach (byte_q[i]) begin
            send_byte(byte_q[i]);
        end
        send_load_end();
        wait_scene_loaded();
        collect_pixels(random_ready);
        check_stream_idle(20);
    endtask

    task automatic idle_after_reset();
        apply_reset();
        repeat (40) begin
            @(negedge clk);
            check_bit("pix_valid", 1'b0, pix_valid);
            check_bit("frame_done", 1'b0, frame_done);
            check_bit("scene_loaded", 1'b0, scene_loaded);
        end
    endtask

    task automatic full_word_scene();
        byte_q = '{8'h33, 8'h22, 8'h11, 8'h02,
                   8'hc0, 8'hb0, 8'ha0, 8'h00,
                   8'h7f, 8'hff, 8'h00, 8'h04};
        run_scene(1'b0);
    endtask

    // Six bytes leave a two-byte tail with run 0
    task automatic partial_word_scene();
        byte_q = '{8'h55, 8'h66, 8'h77, 8'h03, 8'h9a, 8'hbc};
        run_scene(1'b0);
    endtask

    task automatic back_pressure_scene();
        logic [31:0] r;
        byte_q.delete();
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            byte_q.push_back(r[7:0]);
            byte_q.push_back(r[15:8]);
            byte_q.push_back(r[23:16]);
            byte_q.push_back({5'b00000, r[26:24]});
        end
        run_scene(1'b1);
    endtask

    // 155 pixels cover two full frames and part of a third
    task automatic frame_wrap_scene();
        logic [31:0] r;
        byte_q.delete();
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            byte_q.push_back(r[7:0]);
            byte_q.push_back(r[15:8]);
            byte_q.push_back(r[23:16]);
            byte_q.push_back(8'(10 + i));
        end
        run_scene(1'b0);
    endtask

    initial begin
        seed       = 32'h036ec6c6;
        clk        = 1'b0;
        rst        = 1'b1;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        load_end   = 1'b0;
        pix_ready  = 1'b1;

        idle_after_reset();
        full_word_scene();
        partial_word_scene();
        back_pressure_scene();
        frame_wrap_scene();

        $display("TB PASSED");
        $finish;
    end

endmodule : tb_scene_top
